/* flist.f */
verilog/tpl_link_pkg.sv
verilog/tpl_reg_pkg.sv
verilog/tpl_adc_regmap.sv
verilog/tpl_adc_deframer.sv
verilog/tpl_adc_dfmt.sv
verilog/tpl_adc_pn_mon.sv
verilog/tpl_adc_merge.sv
verilog/tpl_adc_top.sv
test/tpl_adc_chk.sv
test/tb_tpl_adc.sv

/* run.sh */
#!/bin/sh
# build and run the transport layer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_tpl_adc \
  -o sim_tb_tpl_adc
out="$(./obj_dir/sim_tb_tpl_adc +verilator+error+limit+100 2>&1 || true)"
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx 'Everything OK'; then
  exit 0
fi
exit 1

/* test/tb_tpl_adc.sv */
// ****************************************
// testbench for the receive transport layer
// clock, reset, stimulus and register tasks
// ****************************************

`timescale 1ns/1ps

module tb_tpl_adc;

  localparam int NC      = tpl_link_pkg::NUM_CHANNELS;
  localparam int TIMEOUT = 20;

  logic                   link_clk;
  logic                   arst_n;
  logic                   link_valid;
  logic [31:0]            link_data;
  logic                   link_ready;
  logic                   reg_req;
  tpl_reg_pkg::reg_req_t  reg_in;
  logic                   reg_ack;
  logic [31:0]            reg_rdata;
  logic [NC-1:0]          enable;
  logic [NC-1:0]          adc_valid;
  tpl_link_pkg::samples_t adc_data;
  logic [31:0]            rng;
  logic [31:0]            rd;
  logic [31:0]            val;
  logic [15:0]            pn0;
  logic [15:0]            pn1;

  tpl_adc_top UUT (
    .link_clk, .arst_n, .link_valid, .link_data, .link_ready, .reg_req, .reg_in,
    .reg_ack, .reg_rdata, .enable, .adc_valid, .adc_data
  );

  bind tpl_adc_top tpl_adc_chk i_chk (
    .link_clk, .arst_n, .link_valid, .link_data, .link_ready, .ctrl, .status,
    .enable, .adc_valid, .adc_data
  );

  always #5 link_clk = ~link_clk;

  // ****************************************
  // helpers
  // ****************************************

  function automatic logic [31:0] lcg_next();
    logic [31:0] hi;
    rng = rng * 32'd1103515245 + 32'd12345;
    hi  = rng;
    rng = rng * 32'd1103515245 + 32'd12345;
    return {hi[31:16], rng[31:16]};
  endfunction

  // next 16 stream bits, MSB first, earlier bits sit at higher indices
  function automatic logic [15:0] pn_step(input logic [15:0] prev, input logic pn15);
    logic [31:0] w;
    int          tap_a;
    int          tap_b;
    w     = {prev, 16'h0000};
    tap_a = pn15 ? 15 : 9;
    tap_b = pn15 ? 14 : 5;
    for (int k = 15; k >= 0; k--) begin
      w[k] = w[k + tap_a] ^ w[k + tap_b];
    end
    return w[15:0];
  endfunction

  // channel c high byte goes out first as octet 2c
  function automatic logic [31:0] beat_of(input logic [15:0] s0, input logic [15:0] s1);
    return {s1[7:0], s1[15:8], s0[7:0], s0[15:8]};
  endfunction

  task automatic fail_with(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      fail_with($sformatf("error %s: expected 0x%0h, actual 0x%0h", name, exp, act));
    end
  endtask

  task automatic bus_cycle(input logic [3:0] addr, input logic we, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int n;
    reg_in.addr  = addr;
    reg_in.we    = we;
    reg_in.wdata = wdata;
    reg_req      = 1'b1;
    n = 0;
    while (!reg_ack) begin
      @(negedge link_clk);
      n++;
      if (n > TIMEOUT) fail_with("reg_ack did not rise after a register request");
    end
    rdata   = reg_rdata;
    reg_req = 1'b0;
    n = 0;
    while (reg_ack) begin
      @(negedge link_clk);
      n++;
      if (n > TIMEOUT) fail_with("reg_ack did not fall after the request was dropped");
    end
  endtask

  task automatic write_register(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(addr, 1'b1, data, unused);
  endtask

  task automatic read_register(input logic [3:0] addr, output logic [31:0] data);
    bus_cycle(addr, 1'b0, 32'h0, data);
  endtask

  task automatic write_and_verify(input string name, input logic [3:0] addr,
                                  input logic [31:0] data);
    logic [31:0] back;
    write_register(addr, data);
    read_register(addr, back);
    check_value(name, data, back);
  endtask

  task automatic send_beat(input logic valid, input logic [31:0] data);
    link_valid = valid;
    link_data  = data;
    @(negedge link_clk);
    link_valid = 1'b0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge link_clk);
  endtask

  // a failed checker assertion ends the run at the next falling edge
  always @(negedge link_clk) begin
    if (UUT.i_chk.fails != 0) fail_with("an assertion in the checker failed");
  end

  // ****************************************
  // test sequence
  // ****************************************

  initial begin
    link_clk   = 1'b0;
    arst_n     = 1'b0;
    link_valid = 1'b0;
    link_data  = '0;
    reg_req    = 1'b0;
    reg_in     = '0;
    rng        = 32'd25;
    idle(5);
    arst_n = 1'b1;

    for (int n = 0; n < 2 && !link_ready; n++) begin
      @(negedge link_clk);
    end
    if (!link_ready) fail_with("link_ready did not rise within 2 cycles of reset release");
    check_value("reset adc_valid", 32'h0, 32'(adc_valid));
    check_value("reset reg_ack", 32'h0, 32'(reg_ack));
    read_register(tpl_reg_pkg::ADDR_STATUS, rd);
    check_value("reset status", 32'h3, rd);

    for (int i = 0; i < 4; i++) begin
      val = lcg_next() & 32'h3;
      write_and_verify("enable readback", tpl_reg_pkg::ADDR_ENABLE, val);
      check_value("enable output", val, 32'(enable));
      write_and_verify("dfmt readback", tpl_reg_pkg::ADDR_DFMT, lcg_next() & 32'h3f);
      write_and_verify("pn_sel readback", tpl_reg_pkg::ADDR_PN_SEL, lcg_next() & 32'h3);
    end

    // raw pass-through with random enables and gaps
    write_register(tpl_reg_pkg::ADDR_DFMT, 32'h0);
    for (int i = 0; i < 4; i++) begin
      write_register(tpl_reg_pkg::ADDR_ENABLE, lcg_next() & 32'h3);
      for (int b = 0; b < 16; b++) begin
        val = lcg_next();
        send_beat(val[31], lcg_next());
      end
    end

    // dfmt on for both channels, sign extend and type from the loop bits
    write_register(tpl_reg_pkg::ADDR_ENABLE, 32'h3);
    for (int combo = 0; combo < 4; combo++) begin
      val = 32'h3 | (combo[0] ? 32'hc : 32'h0) | (combo[1] ? 32'h30 : 32'h0);
      write_register(tpl_reg_pkg::ADDR_DFMT, val);
      repeat (16) send_beat(1'b1, lcg_next());
    end

    // PN9 on channel 0, PN15 on channel 1
    write_register(tpl_reg_pkg::ADDR_PN_SEL, 32'h2);
    val = lcg_next();
    pn0 = val[15:0] | 16'h1;
    pn1 = val[31:16] | 16'h1;
    for (int i = 0; i < 8; i++) begin
      pn0 = pn_step(pn0, 1'b0);
      pn1 = pn_step(pn1, 1'b1);
      send_beat(1'b1, beat_of(pn0, pn1));
    end
    idle(3);
    read_register(tpl_reg_pkg::ADDR_STATUS, rd);
    check_value("pn lock status", 32'h0, rd);

    // one bad word on channel 0, the stream itself carries on unchanged
    pn0 = pn_step(pn0, 1'b0);
    pn1 = pn_step(pn1, 1'b1);
    send_beat(1'b1, beat_of(pn0 ^ 16'h0100, pn1));
    for (int i = 0; i < 4; i++) begin
      pn0 = pn_step(pn0, 1'b0);
      pn1 = pn_step(pn1, 1'b1);
      send_beat(1'b1, beat_of(pn0, pn1));
    end
    idle(3);
    read_register(tpl_reg_pkg::ADDR_STATUS, rd);
    check_value("pn error status", 32'h4, rd);
    write_register(tpl_reg_pkg::ADDR_STATUS, 32'h4);
    read_register(tpl_reg_pkg::ADDR_STATUS, rd);
    check_value("pn error clear", 32'h0, rd);

    idle(4);
    if (UUT.i_chk.fails == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      fail_with("the checker reported assertion failures");
    end
  end

endmodule

/* test/tpl_adc_chk.sv */
// ****************************************
// bound checker for latency, data format
// and PN status of the transport layer
// ****************************************

`timescale 1ns/1ps

module tpl_adc_chk #(
  parameter int RESOLUTION = tpl_link_pkg::DEF_RESOLUTION
) (
  input logic                                  link_clk,
  input logic                                  arst_n,
  input logic                                  link_valid,
  input logic [tpl_link_pkg::LINK_WIDTH-1:0]   link_data,
  input logic                                  link_ready,
  input tpl_reg_pkg::ctrl_t                    ctrl,
  input tpl_reg_pkg::status_t                  status,
  input logic [tpl_link_pkg::NUM_CHANNELS-1:0] enable,
  input logic [tpl_link_pkg::NUM_CHANNELS-1:0] adc_valid,
  input tpl_link_pkg::samples_t                adc_data
);

  localparam int NC = tpl_link_pkg::NUM_CHANNELS;

  int unsigned fails = 0;

  // keep the converter bits, fix up the top one and fill the rest
  function automatic logic [15:0] format_sample(input logic [15:0] s, input logic en,
                                                input logic se, input logic twos);
    logic [15:0] low_mask;
    logic [15:0] r;
    logic        top;
    low_mask = 16'hffff >> (16 - RESOLUTION);
    top = twos ? s[RESOLUTION-1] : ~s[RESOLUTION-1];
    r = s & low_mask;
    r[RESOLUTION-1] = top;
    if (se && top) begin
      r = r | ~low_mask;
    end
    if (!en) begin
      r = s;
    end
    return r;
  endfunction

  // octet 2c is the high byte of channel c
  function automatic tpl_link_pkg::samples_t reorder_and_format(input logic [31:0] d,
                                                                input tpl_reg_pkg::ctrl_t cfg);
    tpl_link_pkg::samples_t s;
    for (int c = 0; c < NC; c++) begin
      s.ch[c] = format_sample({d[16*c +: 8], d[16*c+8 +: 8]}, cfg.dfmt_enable[c],
                              cfg.dfmt_sign_extend[c], cfg.dfmt_type[c]);
    end
    return s;
  endfunction

  // ****************************************
  // assertions
  // ****************************************

  a_link_ready: assert property (@(posedge link_clk) disable iff (!arst_n)
    $past(link_ready) |-> link_ready)
    else begin
      fails++;
      $error("link_ready dropped after it was raised");
    end

  // beat accepted at t shows up at t+3, enable taken one stage before the output
  a_valid: assert property (@(posedge link_clk) disable iff (!arst_n)
    adc_valid == ($past(link_valid, 3) ? $past(enable) : {NC{1'b0}}))
    else begin
      fails++;
      $error("adc_valid differs from delayed link_valid and enable");
    end

  a_data: assert property (@(posedge link_clk) disable iff (!arst_n)
    $past(link_valid, 3) |-> adc_data == reorder_and_format($past(link_data, 3), $past(ctrl, 2)))
    else begin
      fails++;
      $error("adc_data differs from the reordered and formatted link beat");
    end

  // error bits are sticky, one only drops right after a clear strobe for its channel
  a_pn_err: assert property (@(posedge link_clk) disable iff (!arst_n)
    ($past(status.pn_err) & ~status.pn_err & ~$past(ctrl.err_clr)) == {NC{1'b0}})
    else begin
      fails++;
      $error("pn_err dropped without a clear strobe");
    end

endmodule

/* verilog/tpl_adc_top.sv */
// ****************************************
// receive transport layer top level
// ****************************************

`timescale 1ns/1ps

module tpl_adc_top #(
  parameter int CONVERTER_RESOLUTION = tpl_link_pkg::DEF_RESOLUTION,
  parameter int PN_LOCK_COUNT        = 4
) (
  input  logic                                  link_clk,
  input  logic                                  arst_n,
  // link side
  input  logic                                  link_valid,
  input  logic [tpl_link_pkg::LINK_WIDTH-1:0]   link_data,
  output logic                                  link_ready,
  // register port
  input  logic                                  reg_req,
  input  tpl_reg_pkg::reg_req_t                 reg_in,
  output logic                                  reg_ack,
  output logic [31:0]                           reg_rdata,
  // dma side
  output logic [tpl_link_pkg::NUM_CHANNELS-1:0] enable,
  output logic [tpl_link_pkg::NUM_CHANNELS-1:0] adc_valid,
  output tpl_link_pkg::samples_t                adc_data
);

  tpl_reg_pkg::ctrl_t                    ctrl;
  tpl_reg_pkg::status_t                  status;
  tpl_link_pkg::samples_t                raw;
  tpl_link_pkg::samples_t                fmt;
  logic                                  raw_valid;
  logic                                  fmt_valid;
  logic                                  pn_valid;
  logic [tpl_link_pkg::NUM_CHANNELS-1:0] pn_match;
  logic [tpl_link_pkg::NUM_CHANNELS-1:0] pn_oos;

  assign enable = ctrl.enable;

  tpl_adc_regmap i_regmap (
    .link_clk, .arst_n, .reg_req, .reg_in, .reg_ack, .reg_rdata, .ctrl, .status
  );

  tpl_adc_deframer i_deframer (
    .link_clk, .arst_n, .link_valid, .link_data, .link_ready, .raw, .raw_valid
  );

  // ****************************************
  // formatter and PN monitor side by side
  // ****************************************

  tpl_adc_dfmt #(
    .CONVERTER_RESOLUTION (CONVERTER_RESOLUTION)
  ) i_dfmt (
    .link_clk, .arst_n, .ctrl, .raw, .raw_valid, .fmt, .fmt_valid
  );

  tpl_adc_pn_mon #(
    .PN_LOCK_COUNT (PN_LOCK_COUNT)
  ) i_pn_mon (
    .link_clk, .arst_n, .ctrl, .raw, .raw_valid, .pn_match, .pn_oos, .pn_valid
  );

  tpl_adc_merge i_merge (
    .link_clk, .arst_n, .ctrl, .fmt, .fmt_valid, .pn_match, .pn_oos, .pn_valid,
    .adc_valid, .adc_data, .status
  );

endmodule

/* verilog/tpl_adc_merge.sv */
// ****************************************
// dma output stage and sticky PN status
// ****************************************

`timescale 1ns/1ps

module tpl_adc_merge (
  input  logic                                  link_clk,
  input  logic                                  arst_n,
  input  tpl_reg_pkg::ctrl_t                    ctrl,
  input  tpl_link_pkg::samples_t                fmt,
  input  logic                                  fmt_valid,
  input  logic [tpl_link_pkg::NUM_CHANNELS-1:0] pn_match,
  input  logic [tpl_link_pkg::NUM_CHANNELS-1:0] pn_oos,
  input  logic                                  pn_valid,
  output logic [tpl_link_pkg::NUM_CHANNELS-1:0] adc_valid,
  output tpl_link_pkg::samples_t                adc_data,
  output tpl_reg_pkg::status_t                  status
);

  localparam int NC = tpl_link_pkg::NUM_CHANNELS;

  logic [NC-1:0] err_set;

  // a mismatch only counts as an error while the channel is in sync
  assign err_set = {NC{pn_valid}} & ~pn_match & ~pn_oos;

  always_ff @(posedge link_clk or negedge arst_n) begin
    if (!arst_n) begin
      adc_valid     <= '0;
      status.pn_oos <= '1;
      status.pn_err <= '0;
    end else begin
      adc_valid     <= {NC{fmt_valid}} & ctrl.enable;
      status.pn_oos <= pn_oos;
      // new errors win over a clear in the same cycle
      status.pn_err <= (status.pn_err & ~ctrl.err_clr) | err_set;
    end
  end

  always_ff @(posedge link_clk) begin
    adc_data <= fmt;
  end

endmodule

/* verilog/tpl_adc_pn_mon.sv */
// ****************************************
// per-channel PN9 / PN15 monitor
// ****************************************

`timescale 1ns/1ps

module tpl_adc_pn_mon #(
  parameter int PN_LOCK_COUNT = 4
) (
  input  logic                                  link_clk,
  input  logic                                  arst_n,
  input  tpl_reg_pkg::ctrl_t                    ctrl,
  input  tpl_link_pkg::samples_t                raw,
  input  logic                                  raw_valid,
  output logic [tpl_link_pkg::NUM_CHANNELS-1:0] pn_match,
  output logic [tpl_link_pkg::NUM_CHANNELS-1:0] pn_oos,
  output logic                                  pn_valid
);

  localparam int NC  = tpl_link_pkg::NUM_CHANNELS;
  localparam int BPS = tpl_link_pkg::BITS_PER_SAMPLE;
  localparam int CW  = $clog2(PN_LOCK_COUNT + 1);

  logic [NC-1:0][BPS-1:0] prev_q;
  logic [NC-1:0][CW-1:0]  cnt_q;
  logic [NC-1:0]          match;

  // 16 bit-steps, MSB first, bit 0 of the state is the newest bit
  // PN9 a(n) = a(n-9) ^ a(n-5), PN15 a(n) = a(n-15) ^ a(n-14)
  function automatic logic [BPS-1:0] pn_next(input logic [BPS-1:0] prev, input logic sel);
    logic [BPS-1:0] s;
    logic [BPS-1:0] r;
    logic           b;
    s = prev;
    for (int i = BPS-1; i >= 0; i--) begin
      b    = sel ? (s[14] ^ s[13]) : (s[8] ^ s[4]);
      r[i] = b;
      s    = {s[BPS-2:0], b};
    end
    return r;
  endfunction

  always_comb begin
    for (int c = 0; c < NC; c++) begin
      match[c] = (raw.ch[c] == pn_next(prev_q[c], ctrl.pn_seq_sel[c]));
    end
  end

  // ****************************************
  // lock tracking
  // ****************************************

  // count runs that disagree with the current state, flip state after a full run
  always_ff @(posedge link_clk or negedge arst_n) begin
    if (!arst_n) begin
      pn_oos   <= '1;
      cnt_q    <= '0;
      pn_valid <= 1'b0;
    end else begin
      pn_valid <= raw_valid;
      for (int c = 0; c < NC; c++) begin
        if (raw_valid) begin
          if (match[c] == pn_oos[c]) begin
            if (cnt_q[c] == CW'(PN_LOCK_COUNT - 1)) begin
              pn_oos[c] <= ~pn_oos[c];
              cnt_q[c]  <= '0;
            end else begin
              cnt_q[c] <= cnt_q[c] + 1'b1;
            end
          end else begin
            cnt_q[c] <= '0;
          end
        end
      end
    end
  end

  always_ff @(posedge link_clk) begin
    if (raw_valid) begin
      prev_q   <= raw.ch;
      pn_match <= match;
    end
  end

endmodule

/* verilog/tpl_adc_dfmt.sv */
// ****************************************
// per-channel data format conversion
// ****************************************

`timescale 1ns/1ps

module tpl_adc_dfmt #(
  parameter int CONVERTER_RESOLUTION = tpl_link_pkg::DEF_RESOLUTION
) (
  input  logic                   link_clk,
  input  logic                   arst_n,
  input  tpl_reg_pkg::ctrl_t     ctrl,
  input  tpl_link_pkg::samples_t raw,
  input  logic                   raw_valid,
  output tpl_link_pkg::samples_t fmt,
  output logic                   fmt_valid
);

  localparam int NC  = tpl_link_pkg::NUM_CHANNELS;
  localparam int BPS = tpl_link_pkg::BITS_PER_SAMPLE;
  localparam int N   = CONVERTER_RESOLUTION;

  tpl_link_pkg::samples_t fmt_d;

  // offset binary flips the top converter bit, upper bits follow it or go to zero
  function automatic logic [BPS-1:0] convert(input logic [BPS-1:0] s, input logic en,
                                             input logic se, input logic typ);
    logic [BPS-1:0] r;
    logic           msb;
    r   = s;
    msb = s[N-1] ^ ~typ;
    if (en) begin
      r[N-1] = msb;
      for (int i = N; i < BPS; i++) begin
        r[i] = se & msb;
      end
    end
    return r;
  endfunction

  always_comb begin
    for (int c = 0; c < NC; c++) begin
      fmt_d.ch[c] = convert(raw.ch[c], ctrl.dfmt_enable[c], ctrl.dfmt_sign_extend[c],
                            ctrl.dfmt_type[c]);
    end
  end

  always_ff @(posedge link_clk or negedge arst_n) begin
    if (!arst_n) begin
      fmt_valid <= 1'b0;
    end else begin
      fmt_valid <= raw_valid;
    end
  end

  always_ff @(posedge link_clk) begin
    fmt <= fmt_d;
  end

endmodule

/* verilog/tpl_adc_deframer.sv */
// ****************************************
// link beat to per-channel sample reorder
// ****************************************

`timescale 1ns/1ps

module tpl_adc_deframer (
  input  logic                                link_clk,
  input  logic                                arst_n,
  input  logic                                link_valid,
  input  logic [tpl_link_pkg::LINK_WIDTH-1:0] link_data,
  output logic                                link_ready,
  output tpl_link_pkg::samples_t              raw,
  output logic                                raw_valid
);

  localparam int NC  = tpl_link_pkg::NUM_CHANNELS;
  localparam int BPS = tpl_link_pkg::BITS_PER_SAMPLE;
  localparam int OPS = tpl_link_pkg::OCTETS_PER_BEAT / NC;

  tpl_link_pkg::samples_t beat;

  // channel c owns octets OPS*c onwards, first octet lands in the MSB
  always_comb begin
    for (int c = 0; c < NC; c++) begin
      for (int o = 0; o < OPS; o++) begin
        beat.ch[c][BPS-8-8*o +: 8] = link_data[8*(OPS*c+o) +: 8];
      end
    end
  end

  always_ff @(posedge link_clk or negedge arst_n) begin
    if (!arst_n) begin
      link_ready <= 1'b0;
      raw_valid  <= 1'b0;
    end else begin
      // no back-pressure, ready stays up after reset
      link_ready <= 1'b1;
      raw_valid  <= link_valid;
    end
  end

  always_ff @(posedge link_clk) begin
    raw <= beat;
  end

endmodule

/* verilog/tpl_adc_regmap.sv */
// ****************************************
// four-phase register port, control
// registers and status readback
// ****************************************

`timescale 1ns/1ps

module tpl_adc_regmap (
  input  logic                  link_clk,
  input  logic                  arst_n,
  input  logic                  reg_req,
  input  tpl_reg_pkg::reg_req_t reg_in,
  output logic                  reg_ack,
  output logic [31:0]           reg_rdata,
  output tpl_reg_pkg::ctrl_t    ctrl,
  input  tpl_reg_pkg::status_t  status
);

  localparam int NC = tpl_link_pkg::NUM_CHANNELS;

  logic [NC-1:0] enable_q;
  logic [NC-1:0] dfmt_en_q;
  logic [NC-1:0] dfmt_se_q;
  logic [NC-1:0] dfmt_type_q;
  logic [NC-1:0] pn_sel_q;
  logic [NC-1:0] err_clr_q;
  logic          pend_q;
  logic          access;
  logic [31:0]   rdata_d;

  // one access per request, blocked until the ack has been dropped again
  assign access = reg_req & ~reg_ack & ~pend_q;

  always_comb begin
    rdata_d = '0;
    case (reg_in.addr)
      tpl_reg_pkg::ADDR_ENABLE: rdata_d[NC-1:0] = enable_q;
      tpl_reg_pkg::ADDR_DFMT: begin
        rdata_d[tpl_reg_pkg::DFMT_ENABLE_LSB +: NC]   = dfmt_en_q;
        rdata_d[tpl_reg_pkg::DFMT_SIGN_EXT_LSB +: NC] = dfmt_se_q;
        rdata_d[tpl_reg_pkg::DFMT_TYPE_LSB +: NC]     = dfmt_type_q;
      end
      tpl_reg_pkg::ADDR_PN_SEL: rdata_d[NC-1:0] = pn_sel_q;
      tpl_reg_pkg::ADDR_STATUS: rdata_d[$bits(status)-1:0] = status;
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge link_clk or negedge arst_n) begin
    if (!arst_n) begin
      enable_q    <= '0;
      dfmt_en_q   <= '0;
      dfmt_se_q   <= '0;
      dfmt_type_q <= '0;
      pn_sel_q    <= '0;
      err_clr_q   <= '0;
      pend_q      <= 1'b0;
      reg_ack     <= 1'b0;
    end else begin
      // err_clr is a single cycle strobe
      err_clr_q <= '0;
      if (access) begin
        pend_q <= 1'b1;
        if (reg_in.we) begin
          case (reg_in.addr)
            tpl_reg_pkg::ADDR_ENABLE: enable_q <= reg_in.wdata[NC-1:0];
            tpl_reg_pkg::ADDR_DFMT: begin
              dfmt_en_q   <= reg_in.wdata[tpl_reg_pkg::DFMT_ENABLE_LSB +: NC];
              dfmt_se_q   <= reg_in.wdata[tpl_reg_pkg::DFMT_SIGN_EXT_LSB +: NC];
              dfmt_type_q <= reg_in.wdata[tpl_reg_pkg::DFMT_TYPE_LSB +: NC];
            end
            tpl_reg_pkg::ADDR_PN_SEL: pn_sel_q <= reg_in.wdata[NC-1:0];
            tpl_reg_pkg::ADDR_STATUS: err_clr_q <= reg_in.wdata[tpl_reg_pkg::STATUS_ERR_LSB +: NC];
            default: ;
          endcase
        end
      end
      // ack one clock after the access, drop it once req is seen low
      if (pend_q) begin
        pend_q  <= 1'b0;
        reg_ack <= 1'b1;
      end else if (reg_ack && !reg_req) begin
        reg_ack <= 1'b0;
      end
    end
  end

  always_ff @(posedge link_clk) begin
    if (access) begin
      reg_rdata <= rdata_d;
    end
  end

  assign ctrl = '{enable: enable_q, dfmt_enable: dfmt_en_q, dfmt_sign_extend: dfmt_se_q,
                  dfmt_type: dfmt_type_q, pn_seq_sel: pn_sel_q, err_clr: err_clr_q};

endmodule

/* verilog/tpl_reg_pkg.sv */
// ****************************************
// register addresses, field offsets and the
// request, control and status structs
// ****************************************

package tpl_reg_pkg;

  localparam logic [3:0] ADDR_ENABLE = 4'd0;
  localparam logic [3:0] ADDR_DFMT   = 4'd1;
  localparam logic [3:0] ADDR_PN_SEL = 4'd2;
  localparam logic [3:0] ADDR_STATUS = 4'd3;

  // field offsets inside the dfmt and status words
  localparam int DFMT_ENABLE_LSB   = 0;
  localparam int DFMT_SIGN_EXT_LSB = 2;
  localparam int DFMT_TYPE_LSB     = 4;
  localparam int STATUS_ERR_LSB    = 2;

  typedef struct packed {
    logic [3:0]  addr;
    logic        we;
    logic [31:0] wdata;
  } reg_req_t;

  // dfmt_type 1: data already two's complement
  // pn_seq_sel 0: PN9, 1: PN15
  typedef struct packed {
    logic [tpl_link_pkg::NUM_CHANNELS-1:0] enable;
    logic [tpl_link_pkg::NUM_CHANNELS-1:0] dfmt_enable;
    logic [tpl_link_pkg::NUM_CHANNELS-1:0] dfmt_sign_extend;
    logic [tpl_link_pkg::NUM_CHANNELS-1:0] dfmt_type;
    logic [tpl_link_pkg::NUM_CHANNELS-1:0] pn_seq_sel;
    logic [tpl_link_pkg::NUM_CHANNELS-1:0] err_clr;
  } ctrl_t;

  // pn_err above pn_oos, matching the status register layout
  typedef struct packed {
    logic [tpl_link_pkg::NUM_CHANNELS-1:0] pn_err;
    logic [tpl_link_pkg::NUM_CHANNELS-1:0] pn_oos;
  } status_t;

endpackage

/* verilog/tpl_link_pkg.sv */
// ****************************************
// link geometry constants, default converter
// resolution and the per-beat sample struct
// ****************************************

package tpl_link_pkg;

  // fixed geometry, one lane carrying one sample per channel per beat
  localparam int NUM_CHANNELS    = 2;
  localparam int BITS_PER_SAMPLE = 16;
  localparam int OCTETS_PER_BEAT = 4;
  localparam int LINK_WIDTH      = 8 * OCTETS_PER_BEAT;

  // converter resolution used when the top level does not override it
  localparam int DEF_RESOLUTION  = 14;

  // ****************************************
  // sample container
  // ****************************************

  // channel c sits at ch[c], channel 0 in the low half
  typedef struct packed {
    logic [NUM_CHANNELS-1:0][BITS_PER_SAMPLE-1:0] ch;
  } samples_t;

endpackage
